// ==== common/scope_cfg.svh ====
/*
 * Size macros for the scope capture subsystem.
 * Included by the package, every RTL module and the testbench.
 */

`ifndef SCOPE_CFG_SVH
`define SCOPE_CFG_SVH

// number of capture channels
`define SCOPE_NCH 2

// sample width per channel
`define SCOPE_DW 8

// post-trigger delay counter width
`define SCOPE_CW 8

// capture bank address width, 64 words per channel
`define SCOPE_AW 6

`endif

// ==== common/scope_pkg.sv ====
/*
 * Shared types of the scope capture subsystem.
 * Frames, beats and state encodings used between the blocks.
 * Modules pull them in with a wildcard import in their header.
 */

`include "scope_cfg.svh"

package scope_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // stream payloads
  ////////////////////////////////////////////////////////////////////////////

  // one sample per channel, channel 0 in the low bits
  typedef logic [`SCOPE_NCH-1:0][`SCOPE_DW-1:0] smp_frame_t;

  // frame leaving the trigger splitter
  typedef struct packed {
    // set on the frame where the crossing was seen
    logic       trg;
    smp_frame_t frm;
  } split_beat_t;

  // one channel's beat towards the capture memory
  typedef struct packed {
    // final post-trigger sample
    logic                 lst;
    logic [`SCOPE_DW-1:0] dat;
  } chan_beat_t;

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  // trigger polarity
  typedef enum logic {
    EDGE_RISE = 1'b0,
    EDGE_FALL = 1'b1
  } trig_edge_e;

  // per-channel acquisition state
  typedef enum logic [1:0] {
    ACQ_IDLE  = 2'd0,
    ACQ_ARMED = 2'd1,
    ACQ_POST  = 2'd2
  } acq_state_e;

endpackage

// ==== hw/trig_split.sv ====
/*
 * Trigger detector and frame broadcaster.
 * Watches one channel for a level crossing and hands every frame,
 * tagged with the trigger flag, to all channels at once.
 */

`timescale 1ns/10ps

`include "scope_cfg.svh"

module trig_split import scope_pkg::*; (
  input  logic                            sti,
  input  logic                            ctl_rst,
  // frame input
  input  logic                            in_vld,
  input  smp_frame_t                      in_frm,
  output logic                            in_rdy,
  // trigger setup
  input  logic [$clog2(`SCOPE_NCH)-1:0]   cfg_src,
  input  trig_edge_e                      cfg_edge,
  input  logic [`SCOPE_DW-1:0]            cfg_lvl,
  // broadcast output
  output logic                            split_vld,
  output split_beat_t                     split_beat,
  input  logic [`SCOPE_NCH-1:0]           split_rdy
);

  logic                 acc;
  logic                 all_rdy;
  logic [`SCOPE_DW-1:0] cur_smp;
  logic [`SCOPE_DW-1:0] prv_smp;
  logic                 prv_vld;
  logic                 rise;
  logic                 fall;
  logic                 trg;

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  // beat leaves only when every channel takes it
  assign all_rdy = &split_rdy;

  // output register empty or draining
  assign in_rdy = ~split_vld | all_rdy;
  assign acc    = in_vld & in_rdy;

  ////////////////////////////////////////////////////////////////////////////
  // level crossing
  ////////////////////////////////////////////////////////////////////////////

  // sample of the watched channel
  assign cur_smp = in_frm[cfg_src];

  // unsigned compares against the level
  assign rise = prv_vld & (prv_smp <  cfg_lvl) & (cur_smp >= cfg_lvl);
  assign fall = prv_vld & (prv_smp >= cfg_lvl) & (cur_smp <  cfg_lvl);

  assign trg = (cfg_edge == EDGE_RISE) ? rise : fall;

  // history of the watched channel
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      prv_vld <= 1'b0;
    end else if (acc) begin
      prv_vld <= 1'b1;
    end
  end

  always_ff @(posedge sti) begin
    if (acc) begin
      prv_smp <= cur_smp;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      split_vld <= 1'b0;
    end else if (in_rdy) begin
      split_vld <= in_vld;
    end
  end

  // payload held while stalled
  always_ff @(posedge sti) begin
    if (acc) begin
      split_beat.trg <= trg;
      split_beat.frm <= in_frm;
    end
  end

endmodule

// ==== hw/acq/acq.sv ====
/*
 * Per-channel acquisition stage.
 * Armed by ctl_arm, waits for the trigger flag and then passes the
 * trigger beat plus cfg_dly more beats, flagging the final one.
 */

`timescale 1ns/10ps

`include "scope_cfg.svh"

module acq import scope_pkg::*; (
  input  logic                 sti,
  input  logic                 ctl_rst,
  // control and delay setup
  input  logic                 ctl_arm,
  input  logic [`SCOPE_CW-1:0] cfg_dly,
  // sample input
  input  logic                 in_vld,
  input  logic [`SCOPE_DW-1:0] in_dat,
  input  logic                 in_trg,
  output logic                 in_rdy,
  // beat output
  output logic                 out_vld,
  output chan_beat_t           out_beat,
  input  logic                 out_rdy,
  // status
  output acq_state_e           sts_state
);

  acq_state_e           state_q;
  logic [`SCOPE_CW-1:0] cnt_q;
  logic                 acc;
  logic                 fwd;
  logic                 lst;

  // ready when the output is empty or being drained
  assign in_rdy = out_rdy | ~out_vld;
  assign acc    = in_vld & in_rdy;

  // forward only while capturing
  assign fwd = (state_q != ACQ_IDLE);

  // last beat of the capture window
  always_comb begin
    lst = 1'b0;
    if (state_q == ACQ_ARMED) begin
      lst = in_trg & (cfg_dly == '0);
    end else if (state_q == ACQ_POST) begin
      lst = (cnt_q <= `SCOPE_CW'd1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  // cnt_q holds beats still to pass after the current one
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      state_q <= ACQ_IDLE;
      cnt_q   <= '0;
    end else if (ctl_arm) begin
      state_q <= ACQ_ARMED;
    end else if (acc) begin
      case (state_q)
        ACQ_ARMED: begin
          if (in_trg) begin
            cnt_q   <= cfg_dly;
            state_q <= lst ? ACQ_IDLE : ACQ_POST;
          end
        end
        ACQ_POST: begin
          if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
          end
          if (lst) begin
            state_q <= ACQ_IDLE;
          end
        end
        default: begin
          // idle beats are dropped
          state_q <= ACQ_IDLE;
        end
      endcase
    end
  end

  assign sts_state = state_q;

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      out_vld <= 1'b0;
    end else if (in_rdy) begin
      out_vld <= acc & fwd;
    end
  end

  always_ff @(posedge sti) begin
    if (acc) begin
      out_beat.dat <= in_dat;
      out_beat.lst <= lst;
    end
  end

endmodule

// ==== hw/cap_mem.sv ====
/*
 * Capture memory with one circular bank per channel.
 * Channels write at their own pointer; the host reads any bank
 * through a port with one cycle of latency.
 */

`timescale 1ns/10ps

`include "scope_cfg.svh"

module cap_mem import scope_pkg::*; (
  input  logic                                   sti,
  input  logic                                   ctl_rst,
  input  logic                                   ctl_arm,
  // channel write streams
  input  logic       [`SCOPE_NCH-1:0]            ch_vld,
  input  chan_beat_t [`SCOPE_NCH-1:0]            ch_beat,
  output logic       [`SCOPE_NCH-1:0]            ch_rdy,
  // host read port
  input  logic                                   rd_en,
  input  logic       [$clog2(`SCOPE_NCH)-1:0]    rd_ch,
  input  logic       [`SCOPE_AW-1:0]             rd_adr,
  output logic                                   rd_vld,
  output logic       [`SCOPE_DW-1:0]             rd_dat,
  // status
  output logic       [`SCOPE_NCH-1:0]            sts_done,
  output logic       [`SCOPE_NCH-1:0][`SCOPE_AW-1:0] sts_ptr
);

  logic [`SCOPE_DW-1:0]          bnk_rd [`SCOPE_NCH];
  logic [$clog2(`SCOPE_NCH)-1:0] rd_ch_q;

  ////////////////////////////////////////////////////////////////////////////
  // banks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar n = 0; n < `SCOPE_NCH; n++) begin : bank_g
    logic [`SCOPE_DW-1:0] mem [2**`SCOPE_AW];
    logic [`SCOPE_AW-1:0] ptr_q;
    logic                 done_q;
    logic                 rd_sel;
    logic                 wr;

    // host read owns the bank port this cycle
    assign rd_sel    = rd_en & (rd_ch == n);
    assign ch_rdy[n] = ~rd_sel;
    assign wr        = ch_vld[n] & ~rd_sel;

    always_ff @(posedge sti) begin
      if (rd_sel) begin
        bnk_rd[n] <= mem[rd_adr];
      end else if (wr) begin
        mem[ptr_q] <= ch_beat[n].dat;
      end
    end

    // pointer wraps, done latches on the last beat
    always_ff @(posedge sti) begin
      if (ctl_rst || ctl_arm) begin
        ptr_q  <= '0;
        done_q <= 1'b0;
      end else if (wr) begin
        ptr_q <= ptr_q + 1'b1;
        if (ch_beat[n].lst) begin
          done_q <= 1'b1;
        end
      end
    end

    assign sts_ptr[n]  = ptr_q;
    assign sts_done[n] = done_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // read return
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= rd_en;
    end
  end

  // remember which bank answers
  always_ff @(posedge sti) begin
    if (rd_en) begin
      rd_ch_q <= rd_ch;
    end
  end

  assign rd_dat = bnk_rd[rd_ch_q];

endmodule

// ==== hw/scope_top.sv ====
/*
 * Top of the scope capture subsystem.
 * Trigger splitter, one acquisition stage per channel and the
 * capture memory, configured through plain ports.
 */

`timescale 1ns/10ps

`include "scope_cfg.svh"

module scope_top import scope_pkg::*; (
  input  logic                                   sti,
  input  logic                                   ctl_rst,
  // frame input
  input  logic                                   in_vld,
  input  smp_frame_t                             in_frm,
  output logic                                   in_rdy,
  // configuration
  input  logic       [$clog2(`SCOPE_NCH)-1:0]    cfg_src,
  input  trig_edge_e                             cfg_edge,
  input  logic       [`SCOPE_DW-1:0]             cfg_lvl,
  input  logic       [`SCOPE_CW-1:0]             cfg_dly,
  input  logic                                   ctl_arm,
  // host read port
  input  logic                                   rd_en,
  input  logic       [$clog2(`SCOPE_NCH)-1:0]    rd_ch,
  input  logic       [`SCOPE_AW-1:0]             rd_adr,
  output logic                                   rd_vld,
  output logic       [`SCOPE_DW-1:0]             rd_dat,
  // status
  output acq_state_e [`SCOPE_NCH-1:0]            sts_state,
  output logic       [`SCOPE_NCH-1:0]            sts_done,
  output logic       [`SCOPE_NCH-1:0][`SCOPE_AW-1:0] sts_ptr
);

  // splitter to channels
  logic                        split_vld;
  split_beat_t                 split_beat;
  logic       [`SCOPE_NCH-1:0] split_rdy;
  logic                        acq_vld;

  // channels to memory
  logic       [`SCOPE_NCH-1:0] ch_vld;
  chan_beat_t [`SCOPE_NCH-1:0] ch_beat;
  logic       [`SCOPE_NCH-1:0] ch_rdy;

  trig_split split_i (
    .sti        (sti),
    .ctl_rst    (ctl_rst),
    .in_vld     (in_vld),
    .in_frm     (in_frm),
    .in_rdy     (in_rdy),
    .cfg_src    (cfg_src),
    .cfg_edge   (cfg_edge),
    .cfg_lvl    (cfg_lvl),
    .split_vld  (split_vld),
    .split_beat (split_beat),
    .split_rdy  (split_rdy)
  );

  // beat offered to the channels only when every one of them takes it
  assign acq_vld = split_vld & (&split_rdy);

  // each channel sees its own sample and the shared trigger flag
  for (genvar n = 0; n < `SCOPE_NCH; n++) begin : acq_g
    acq acq_i (
      .sti       (sti),
      .ctl_rst   (ctl_rst),
      .ctl_arm   (ctl_arm),
      .cfg_dly   (cfg_dly),
      .in_vld    (acq_vld),
      .in_dat    (split_beat.frm[n]),
      .in_trg    (split_beat.trg),
      .in_rdy    (split_rdy[n]),
      .out_vld   (ch_vld[n]),
      .out_beat  (ch_beat[n]),
      .out_rdy   (ch_rdy[n]),
      .sts_state (sts_state[n])
    );
  end

  cap_mem mem_i (
    .sti      (sti),
    .ctl_rst  (ctl_rst),
    .ctl_arm  (ctl_arm),
    .ch_vld   (ch_vld),
    .ch_beat  (ch_beat),
    .ch_rdy   (ch_rdy),
    .rd_en    (rd_en),
    .rd_ch    (rd_ch),
    .rd_adr   (rd_adr),
    .rd_vld   (rd_vld),
    .rd_dat   (rd_dat),
    .sts_done (sts_done),
    .sts_ptr  (sts_ptr)
  );

endmodule

// ==== sim/scope_tb.sv ====
/*
 * Directed testbench for the scope capture subsystem.
 * Each test task streams frames into the DUT, then reads the capture
 * banks back and compares them with a model kept here.
 */

`timescale 1ns/10ps

`include "scope_cfg.svh"

module scope_tb import scope_pkg::*; ();

  localparam int NCH   = `SCOPE_NCH;
  localparam int DEPTH = 2**`SCOPE_AW;
  localparam int TMO   = 500;

  typedef logic [$clog2(`SCOPE_NCH)-1:0] ch_t;
  typedef logic [`SCOPE_AW-1:0]          adr_t;
  typedef logic [`SCOPE_DW-1:0]          smp_t;

  logic                                   sti;
  logic                                   ctl_rst;
  logic                                   in_vld;
  smp_frame_t                             in_frm;
  logic                                   in_rdy;
  ch_t                                    cfg_src;
  trig_edge_e                             cfg_edge;
  smp_t                                   cfg_lvl;
  logic       [`SCOPE_CW-1:0]             cfg_dly;
  logic                                   ctl_arm;
  logic                                   rd_en;
  ch_t                                    rd_ch;
  adr_t                                   rd_adr;
  logic                                   rd_vld;
  smp_t                                   rd_dat;
  acq_state_e [`SCOPE_NCH-1:0]            sts_state;
  logic       [`SCOPE_NCH-1:0]            sts_done;
  logic       [`SCOPE_NCH-1:0][`SCOPE_AW-1:0] sts_ptr;

  // model state, shared by all channels since they see the same trigger
  acq_state_e           m_state;
  logic [`SCOPE_CW-1:0] m_left;
  smp_t                 m_prv;
  logic                 m_prv_vld;
  smp_t                 m_bank [NCH][DEPTH];
  adr_t                 m_ptr [NCH];
  logic                 m_done [NCH];
  int                   m_trg_pos;
  int                   seed;
  int                   err_cnt;

  scope_top dut_i (
    .sti       (sti),
    .ctl_rst   (ctl_rst),
    .in_vld    (in_vld),
    .in_frm    (in_frm),
    .in_rdy    (in_rdy),
    .cfg_src   (cfg_src),
    .cfg_edge  (cfg_edge),
    .cfg_lvl   (cfg_lvl),
    .cfg_dly   (cfg_dly),
    .ctl_arm   (ctl_arm),
    .rd_en     (rd_en),
    .rd_ch     (rd_ch),
    .rd_adr    (rd_adr),
    .rd_vld    (rd_vld),
    .rd_dat    (rd_dat),
    .sts_state (sts_state),
    .sts_done  (sts_done),
    .sts_ptr   (sts_ptr)
  );

  // 100 ns period
  initial begin
    sti = 1'b0;
    forever begin
      #50 sti = ~sti;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t %s: got %0h, expected %0h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Simulation FAILED");
    $fatal(1, "wait timed out");
  endtask

  // inputs change 10 ns after the rising edge
  task automatic tick();
    @(posedge sti);
    #10;
  endtask

  function automatic smp_frame_t mk_frame(input smp_t a, input smp_t b);
    smp_frame_t f;
    f    = '0;
    f[0] = a;
    f[1] = b;
    return f;
  endfunction

  // one accepted frame through the trigger rule and the channel rule
  task automatic model_frame(input smp_frame_t frm);
    smp_t cur;
    logic trg;
    logic fwd;
    logic lst;
    cur = frm[cfg_src];
    if (cfg_edge == EDGE_RISE) begin
      trg = m_prv_vld && (m_prv < cfg_lvl) && (cur >= cfg_lvl);
    end else begin
      trg = m_prv_vld && (m_prv >= cfg_lvl) && (cur < cfg_lvl);
    end
    m_prv     = cur;
    m_prv_vld = 1'b1;
    fwd       = (m_state != ACQ_IDLE);
    lst       = 1'b0;
    if (m_state == ACQ_ARMED && trg) begin
      // m_left counts beats still due after the trigger beat
      m_left    = cfg_dly;
      m_trg_pos = int'(m_ptr[0]);
      lst       = (cfg_dly == '0);
      m_state   = lst ? ACQ_IDLE : ACQ_POST;
    end else if (m_state == ACQ_POST) begin
      m_left = m_left - 1'b1;
      lst    = (m_left == '0);
      if (lst) begin
        m_state = ACQ_IDLE;
      end
    end
    if (fwd) begin
      for (int n = 0; n < NCH; n++) begin
        m_bank[n][m_ptr[n]] = frm[n];
        m_ptr[n]            = m_ptr[n] + 1'b1;
        if (lst) begin
          m_done[n] = 1'b1;
        end
      end
    end
  endtask

  task automatic send_frame(input smp_frame_t frm);
    int t;
    in_vld = 1'b1;
    in_frm = frm;
    t      = 0;
    @(negedge sti);
    while (!in_rdy) begin
      t++;
      if (t > TMO) begin
        fail_timeout("in_rdy");
      end
      @(negedge sti);
    end
    model_frame(frm);
    tick();
    in_vld = 1'b0;
  endtask

  // read data returns exactly one cycle after the request
  task automatic host_read(input ch_t ch, input adr_t adr, output smp_t dat);
    rd_en  = 1'b1;
    rd_ch  = ch;
    rd_adr = adr;
    tick();
    rd_en = 1'b0;
    @(negedge sti);
    check_eq("rd_vld", 32'(rd_vld), 1);
    dat = rd_dat;
    tick();
    check_eq("rd_vld", 32'(rd_vld), 0);
  endtask

  task automatic arm_all();
    ctl_arm = 1'b1;
    tick();
    ctl_arm = 1'b0;
    m_state = ACQ_ARMED;
    for (int n = 0; n < NCH; n++) begin
      m_ptr[n]  = '0;
      m_done[n] = 1'b0;
    end
    check_status();
  endtask

  task automatic check_status();
    for (int n = 0; n < NCH; n++) begin
      check_eq($sformatf("sts_state[%0d]", n), 32'(sts_state[n]), 32'(m_state));
      check_eq($sformatf("sts_done[%0d]", n), 32'(sts_done[n]), 32'(m_done[n]));
      check_eq($sformatf("sts_ptr[%0d]", n), 32'(sts_ptr[n]), 32'(m_ptr[n]));
    end
  endtask

  // wait for the model pointers, then flush the two-stage pipeline
  task automatic wait_settled();
    int   t;
    logic same;
    t    = 0;
    same = 1'b0;
    while (!same) begin
      @(negedge sti);
      same = 1'b1;
      for (int n = 0; n < NCH; n++) begin
        if (sts_ptr[n] != m_ptr[n] || sts_done[n] != m_done[n]) begin
          same = 1'b0;
        end
      end
      t++;
      if (t > TMO) begin
        fail_timeout("capture pointers and done flags");
      end
    end
    repeat (3) tick();
  endtask

  task automatic check_bank(input int n, input int first, input int count);
    smp_t dat;
    adr_t adr;
    for (int k = 0; k < count; k++) begin
      adr = adr_t'(first + k);
      host_read(ch_t'(n), adr, dat);
      check_eq($sformatf("rd_dat ch%0d adr %0d", n, adr), 32'(dat), 32'(m_bank[n][adr]));
    end
  endtask

  // trigger beat plus cfg_dly beats, ending at the pointer
  task automatic check_capture();
    check_status();
    for (int n = 0; n < NCH; n++) begin
      check_eq($sformatf("sts_done[%0d]", n), 32'(sts_done[n]), 1);
      check_eq("post count", int'(sts_ptr[n]) - m_trg_pos, int'(cfg_dly) + 1);
      check_bank(n, m_trg_pos, int'(cfg_dly) + 1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_idle();
    // stream input open and no read pending out of reset
    check_eq("in_rdy", 32'(in_rdy), 1);
    check_eq("rd_vld", 32'(rd_vld), 0);
    check_status();
    for (int i = 0; i < 4; i++) begin
      send_frame(mk_frame(8'(i + 1), 8'(i + 2)));
    end
    wait_settled();
    check_status();
  endtask

  task automatic test_rise_ch0();
    smp_t dat_l;
    cfg_src  = ch_t'(0);
    cfg_edge = EDGE_RISE;
    cfg_lvl  = 8'h40;
    cfg_dly  = 8'd5;
    arm_all();
    // ramp of 3 per frame on channel 0
    for (int i = 0; i < 16; i++) begin
      send_frame(mk_frame(8'(8'h30 + 3 * i), 8'(8'ha0 - 2 * i)));
    end
    wait_settled();
    check_capture();
    // five ramp steps of 3 after the trigger sample
    host_read(ch_t'(0), adr_t'(m_ptr[0] - 1'b1), dat_l);
    check_eq("rd_dat last", 32'(dat_l), 32'(8'(m_bank[0][m_trg_pos] + 8'd15)));
  endtask

  task automatic test_fall_ch1();
    smp_t dat;
    cfg_src  = ch_t'(1);
    cfg_edge = EDGE_FALL;
    cfg_lvl  = 8'h50;
    cfg_dly  = '0;
    arm_all();
    for (int i = 0; i < 10; i++) begin
      send_frame(mk_frame(8'(7 * i + 1), 8'(8'h70 - 5 * i)));
    end
    wait_settled();
    check_capture();
    host_read(ch_t'(1), adr_t'(m_trg_pos), dat);
    check_eq("rd_dat below level", 32'(dat < cfg_lvl), 1);
    host_read(ch_t'(1), adr_t'(m_trg_pos - 1), dat);
    check_eq("rd_dat before fall", 32'(dat >= cfg_lvl), 1);
    host_read(ch_t'(0), adr_t'(m_trg_pos), dat);
    check_eq("rd_dat ch0 same frame", 32'(dat), 32'(8'(7 * m_trg_pos + 1)));
  endtask

  task automatic test_no_trig();
    cfg_src  = ch_t'(0);
    cfg_edge = EDGE_RISE;
    cfg_lvl  = 8'hf0;
    cfg_dly  = 8'd3;
    arm_all();
    // 70 frames wrap the 64-word bank
    for (int i = 0; i < 70; i++) begin
      send_frame(mk_frame(8'(8'h10 + i % 32), 8'($random(seed))));
    end
    wait_settled();
    check_status();
    for (int n = 0; n < NCH; n++) begin
      check_eq($sformatf("sts_state[%0d]", n), 32'(sts_state[n]), 32'(ACQ_ARMED));
      check_eq($sformatf("sts_done[%0d]", n), 32'(sts_done[n]), 0);
      check_eq($sformatf("sts_ptr[%0d]", n), 32'(sts_ptr[n]), 70 % DEPTH);
      check_bank(n, 70 - 6, 6);
    end
  endtask

  task automatic test_backpressure();
    smp_frame_t frm;
    int         i;
    int         t;
    logic       acc;
    cfg_src  = ch_t'(0);
    cfg_edge = EDGE_RISE;
    cfg_lvl  = 8'h80;
    cfg_dly  = 8'd10;
    arm_all();
    i = 0;
    t = 0;
    while (i < 20) begin
      t++;
      if (t > TMO) begin
        fail_timeout("random stream to finish");
      end
      // valid only drops after a transfer
      if (!in_vld) begin
        frm    = mk_frame(8'(8'h70 + 4 * i), 8'($random(seed)));
        in_frm = frm;
        in_vld = 1'($random(seed));
      end
      // host reads take a bank port and stall that channel
      rd_en  = 1'($random(seed));
      rd_ch  = ch_t'($random(seed));
      rd_adr = adr_t'($random(seed));
      @(negedge sti);
      acc = in_vld && in_rdy;
      if (acc) begin
        model_frame(in_frm);
      end
      tick();
      if (acc) begin
        i++;
        in_vld = 1'b0;
      end
    end
    in_vld = 1'b0;
    rd_en  = 1'b0;
    wait_settled();
    check_status();
    for (int n = 0; n < NCH; n++) begin
      check_eq($sformatf("sts_done[%0d]", n), 32'(sts_done[n]), 1);
      check_bank(n, 0, int'(m_ptr[n]));
    end
  endtask

  task automatic test_rearm();
    for (int n = 0; n < NCH; n++) begin
      check_eq($sformatf("sts_done[%0d]", n), 32'(sts_done[n]), 1);
    end
    cfg_src  = ch_t'(0);
    cfg_edge = EDGE_RISE;
    cfg_lvl  = 8'h20;
    cfg_dly  = 8'd2;
    // arm check covers cleared done and pointers
    arm_all();
    for (int i = 0; i < 10; i++) begin
      send_frame(mk_frame(8'(8'h10 + 4 * i), 8'(i)));
    end
    wait_settled();
    check_capture();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed      = 92701;
    err_cnt   = 0;
    ctl_rst   = 1'b1;
    in_vld    = 1'b0;
    in_frm    = '0;
    cfg_src   = '0;
    cfg_edge  = EDGE_RISE;
    cfg_lvl   = '0;
    cfg_dly   = '0;
    ctl_arm   = 1'b0;
    rd_en     = 1'b0;
    rd_ch     = '0;
    rd_adr    = '0;
    m_state   = ACQ_IDLE;
    m_left    = '0;
    m_prv     = '0;
    m_prv_vld = 1'b0;
    m_trg_pos = 0;
    for (int n = 0; n < NCH; n++) begin
      m_ptr[n]  = '0;
      m_done[n] = 1'b0;
    end
    repeat (3) @(posedge sti);
    #10;
    ctl_rst = 1'b0;
    test_idle();
    test_rise_ch0();
    test_fall_ch1();
    test_no_trig();
    test_backpressure();
    test_rearm();
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+common
common/scope_pkg.sv
hw/trig_split.sv
hw/acq/acq.sv
hw/cap_mem.sv
hw/scope_top.sv
sim/scope_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the scope testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module scope_tb -o scope_sim || exit 1
out=$(./obj_dir/scope_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1
